/* enable_gen_settings.svh */
// Build-time widths and counts for the three-channel enable generator
`ifndef ENABLE_GEN_SETTINGS_SVH
`define ENABLE_GEN_SETTINGS_SVH

// Width of the period counter, the period and every threshold (8 to 32)
`define ENABLE_GEN_COUNTER_WIDTH 16

// Number of enable outputs, one comparator per channel
`define ENABLE_GEN_N_CHANNELS 3

// Control, period and one threshold per channel
`define ENABLE_GEN_N_REGISTERS 5

// AXI-lite bus widths
`define ENABLE_GEN_AXIL_ADDR_WIDTH 8
`define ENABLE_GEN_AXIL_DATA_WIDTH 32

`endif

/* axil_pkg.sv */
// AXI-lite request and response channel structs
// Bus engine state encoding for single-transaction slaves
`include "enable_gen_settings.svh"

package axil_pkg;

    // Everything the master drives
    typedef struct packed {
        logic [`ENABLE_GEN_AXIL_ADDR_WIDTH-1:0] awaddr;
        logic                                   awvalid;
        logic [`ENABLE_GEN_AXIL_DATA_WIDTH-1:0] wdata;
        logic                                   wvalid;
        logic                                   bready;
        logic [`ENABLE_GEN_AXIL_ADDR_WIDTH-1:0] araddr;
        logic                                   arvalid;
        logic                                   rready;
    } axil_req_t;

    // Everything the slave drives, responses are always OKAY
    typedef struct packed {
        logic                                   awready;
        logic                                   wready;
        logic                                   bvalid;
        logic                                   arready;
        logic                                   rvalid;
        logic [`ENABLE_GEN_AXIL_DATA_WIDTH-1:0] rdata;
    } axil_resp_t;

    typedef enum logic [1:0] {IDLE, WRITE_ACK, WRITE_RESP, READ_DATA} axil_state_e;

endpackage

/* enable_gen_pkg.sv */
// Register map, configuration struct and counter state struct
// for the enable generator
`include "enable_gen_settings.svh"

package enable_gen_pkg;

    // Word index of each mapped register, byte address is index times four
    typedef enum logic [`ENABLE_GEN_AXIL_ADDR_WIDTH-3:0] {
        CONTROL     = 0,
        PERIOD      = 1,
        THRESHOLD_1 = 2,
        THRESHOLD_2 = 3,
        THRESHOLD_3 = 4
    } reg_index_e;

    typedef struct packed {
        logic                                 run;
        logic                                 use_ext_timebase;
        logic [`ENABLE_GEN_COUNTER_WIDTH-1:0] period;
        logic [`ENABLE_GEN_N_CHANNELS-1:0][`ENABLE_GEN_COUNTER_WIDTH-1:0] thresholds;
    } gen_config_t;

    // Step is high in the cycle in which count has just taken a new value
    typedef struct packed {
        logic [`ENABLE_GEN_COUNTER_WIDTH-1:0] count;
        logic                                 step;
    } counter_state_t;

endpackage

/* axil_register_cu.sv */
// AXI-lite slave with single write and read transactions
// Address decode and storage of the generator configuration
`timescale 1ns/1ps
`include "enable_gen_settings.svh"

module axil_register_cu (
    input  logic                        clock,
    input  logic                        reset,
    input  axil_pkg::axil_req_t         axil_req,
    output axil_pkg::axil_resp_t        axil_resp,
    output enable_gen_pkg::gen_config_t config_out
);

    localparam int ADDR_WIDTH    = `ENABLE_GEN_AXIL_ADDR_WIDTH;
    localparam int DATA_WIDTH    = `ENABLE_GEN_AXIL_DATA_WIDTH;
    localparam int COUNTER_WIDTH = `ENABLE_GEN_COUNTER_WIDTH;

    axil_pkg::axil_state_e      state;
    logic [ADDR_WIDTH-1:0]      addr_q;
    logic [DATA_WIDTH-1:0]      wdata_q;
    enable_gen_pkg::reg_index_e reg_index;
    logic                       mapped;
    logic                       write_enable;
    logic [DATA_WIDTH-1:0]      read_value;

    // Byte address to word index, the two low address bits are ignored
    assign reg_index = enable_gen_pkg::reg_index_e'(addr_q[ADDR_WIDTH-1:2]);
    assign mapped = int'(addr_q[ADDR_WIDTH-1:2]) < `ENABLE_GEN_N_REGISTERS;

    // The register takes the data at the end of the awready/wready cycle
    assign write_enable = (state == axil_pkg::WRITE_ACK) && mapped;

    // Latch the transaction address and data when it is accepted in IDLE
    always_ff @(posedge clock) begin
        if (state == axil_pkg::IDLE) begin
            if (axil_req.awvalid && axil_req.wvalid) begin
                addr_q  <= axil_req.awaddr;
                wdata_q <= axil_req.wdata;
            end else if (axil_req.arvalid) begin
                addr_q <= axil_req.araddr;
            end
        end
    end

    // Bus engine, writes take priority over reads
    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= axil_pkg::IDLE;
            axil_resp <= '0;
        end else begin
            case (state)
                axil_pkg::IDLE: begin
                    if (axil_req.awvalid && axil_req.wvalid) begin
                        axil_resp.awready <= 1'b1;
                        axil_resp.wready  <= 1'b1;
                        state             <= axil_pkg::WRITE_ACK;
                    end else if (axil_req.arvalid) begin
                        axil_resp.arready <= 1'b1;
                        state             <= axil_pkg::READ_DATA;
                    end
                end
                axil_pkg::WRITE_ACK: begin
                    axil_resp.awready <= 1'b0;
                    axil_resp.wready  <= 1'b0;
                    axil_resp.bvalid  <= 1'b1;
                    state             <= axil_pkg::WRITE_RESP;
                end
                axil_pkg::WRITE_RESP: begin
                    if (axil_req.bready) begin
                        axil_resp.bvalid <= 1'b0;
                        state            <= axil_pkg::IDLE;
                    end
                end
                axil_pkg::READ_DATA: begin
                    // First cycle here is the arready cycle, data follows it
                    if (axil_resp.arready) begin
                        axil_resp.arready <= 1'b0;
                        axil_resp.rvalid  <= 1'b1;
                        axil_resp.rdata   <= read_value;
                    end else if (axil_req.rready) begin
                        axil_resp.rvalid <= 1'b0;
                        state            <= axil_pkg::IDLE;
                    end
                end
                default: begin
                    state <= axil_pkg::IDLE;
                end
            endcase
        end
    end

    // Configuration storage, masked to the width each field holds
    always_ff @(posedge clock) begin
        if (reset) begin
            config_out <= '0;
        end else if (write_enable) begin
            case (reg_index)
                enable_gen_pkg::CONTROL: begin
                    config_out.run              <= wdata_q[0];
                    config_out.use_ext_timebase <= wdata_q[1];
                end
                enable_gen_pkg::PERIOD:
                    config_out.period <= wdata_q[COUNTER_WIDTH-1:0];
                enable_gen_pkg::THRESHOLD_1:
                    config_out.thresholds[0] <= wdata_q[COUNTER_WIDTH-1:0];
                enable_gen_pkg::THRESHOLD_2:
                    config_out.thresholds[1] <= wdata_q[COUNTER_WIDTH-1:0];
                enable_gen_pkg::THRESHOLD_3:
                    config_out.thresholds[2] <= wdata_q[COUNTER_WIDTH-1:0];
                default: begin
                end
            endcase
        end
    end

    // Read data is zero-extended, unmapped words read as zero
    always_comb begin
        read_value = '0;
        if (mapped) begin
            case (reg_index)
                enable_gen_pkg::CONTROL:
                    read_value = DATA_WIDTH'({config_out.use_ext_timebase, config_out.run});
                enable_gen_pkg::PERIOD:
                    read_value = DATA_WIDTH'(config_out.period);
                enable_gen_pkg::THRESHOLD_1:
                    read_value = DATA_WIDTH'(config_out.thresholds[0]);
                enable_gen_pkg::THRESHOLD_2:
                    read_value = DATA_WIDTH'(config_out.thresholds[1]);
                enable_gen_pkg::THRESHOLD_3:
                    read_value = DATA_WIDTH'(config_out.thresholds[2]);
                default:
                    read_value = '0;
            endcase
        end
    end

endmodule

/* enable_counter.sv */
// Period counter with internal or external timebase
// Rising-edge detect on the timebase input and run enable gating
`timescale 1ns/1ps
`include "enable_gen_settings.svh"

module enable_counter (
    input  logic                           clock,
    input  logic                           reset,
    input  enable_gen_pkg::gen_config_t    gen_config,
    input  logic                           gen_enable_in,
    input  logic                           ext_timebase,
    output enable_gen_pkg::counter_state_t counter_state
);

    localparam int COUNTER_WIDTH = `ENABLE_GEN_COUNTER_WIDTH;

    logic                     timebase_q;
    logic                     timebase_rise;
    logic                     tick;
    logic                     active;
    logic [COUNTER_WIDTH-1:0] next_count;

    // Timebase is taken as synchronous to clock, a rise is high after low
    assign timebase_rise = ext_timebase && !timebase_q;

    // Every clock is a tick unless the external timebase is selected
    assign tick = gen_config.use_ext_timebase ? timebase_rise : 1'b1;

    // Either the bus bit or the external level runs the counter
    assign active = gen_config.run || gen_enable_in;

    // A full cycle is period plus one ticks
    always_comb begin
        if (counter_state.count == gen_config.period) begin
            next_count = '0;
        end else begin
            next_count = counter_state.count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            timebase_q <= 1'b0;
        end else begin
            timebase_q <= ext_timebase;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            counter_state <= '0;
        end else if (!active) begin
            // Stopped counter restarts from zero
            counter_state.count <= '0;
            counter_state.step  <= 1'b0;
        end else if (tick) begin
            counter_state.count <= next_count;
            counter_state.step  <= 1'b1;
        end else begin
            counter_state.step <= 1'b0;
        end
    end

endmodule

/* enable_comparator_bank.sv */
// Threshold comparators, one per channel
// Registered one-clock enable pulses on each new count
`timescale 1ns/1ps
`include "enable_gen_settings.svh"

module enable_comparator_bank (
    input  logic                              clock,
    input  logic                              reset,
    input  enable_gen_pkg::gen_config_t       gen_config,
    input  enable_gen_pkg::counter_state_t    counter_state,
    output logic [`ENABLE_GEN_N_CHANNELS-1:0] enable_out
);

    localparam int N_CHANNELS = `ENABLE_GEN_N_CHANNELS;

    logic [N_CHANNELS-1:0] match;

    // Only a freshly updated count can fire a channel, so a count that
    // waits at the threshold between external ticks gives a single pulse
    always_comb begin
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            match[ch] = counter_state.step
                && (counter_state.count == gen_config.thresholds[ch]);
        end
    end

    // One clock of latency from the counter update to the pulse
    always_ff @(posedge clock) begin
        if (reset) begin
            enable_out <= '0;
        end else begin
            enable_out <= match;
        end
    end

endmodule

/* enable_generator.sv */
// Top level of the three-channel enable generator
// Register unit, period counter and comparator bank
`timescale 1ns/1ps
`include "enable_gen_settings.svh"

module enable_generator (
    input  logic                              clock,
    input  logic                              reset,
    input  axil_pkg::axil_req_t               axil_req,
    output axil_pkg::axil_resp_t              axil_resp,
    input  logic                              ext_timebase,
    input  logic                              gen_enable_in,
    output logic [`ENABLE_GEN_N_CHANNELS-1:0] enable_out
);

    enable_gen_pkg::gen_config_t    gen_config;
    enable_gen_pkg::counter_state_t counter_state;

    // Configuration registers on the bus side
    axil_register_cu register_cu (
        .clock      (clock),
        .reset      (reset),
        .axil_req   (axil_req),
        .axil_resp  (axil_resp),
        .config_out (gen_config)
    );

    enable_counter counter (
        .clock         (clock),
        .reset         (reset),
        .gen_config    (gen_config),
        .gen_enable_in (gen_enable_in),
        .ext_timebase  (ext_timebase),
        .counter_state (counter_state)
    );

    enable_comparator_bank comparators (
        .clock         (clock),
        .reset         (reset),
        .gen_config    (gen_config),
        .counter_state (counter_state),
        .enable_out    (enable_out)
    );

endmodule

/* enable_generator_tb_bus.svh */
// AXI-lite single write and read tasks for the testbench
// Both tasks give up after a fixed number of cycles and report a hang

localparam int BUS_WAIT_LIMIT = 16;

task automatic write_register(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] data);
    int waited;
    waited = 0;
    @(posedge clock);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wvalid  <= 1'b1;
    @(posedge clock);
    while (!(axil_resp.awready && axil_resp.wready) && waited < BUS_WAIT_LIMIT) begin
        @(posedge clock);
        waited++;
    end
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    if (!(axil_resp.awready && axil_resp.wready)) begin
        $display("Bus hang: write to address 0x%02h was never accepted", addr);
        error_count++;
    end else begin
        axil_req.bready <= 1'b1;
        waited = 0;
        @(posedge clock);
        while (!axil_resp.bvalid && waited < BUS_WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        axil_req.bready <= 1'b0;
        if (!axil_resp.bvalid) begin
            $display("Bus hang: no write response for address 0x%02h", addr);
            error_count++;
        end
    end
endtask

task automatic read_register(input logic [ADDR_WIDTH-1:0] addr,
                             output logic [DATA_WIDTH-1:0] data, output logic ok);
    int waited;
    waited = 0;
    ok = 1'b0;
    data = '0;
    @(posedge clock);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    @(posedge clock);
    while (!axil_resp.arready && waited < BUS_WAIT_LIMIT) begin
        @(posedge clock);
        waited++;
    end
    axil_req.arvalid <= 1'b0;
    if (!axil_resp.arready) begin
        $display("Bus hang: read of address 0x%02h was never accepted", addr);
        error_count++;
    end else begin
        axil_req.rready <= 1'b1;
        waited = 0;
        @(posedge clock);
        while (!axil_resp.rvalid && waited < BUS_WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        axil_req.rready <= 1'b0;
        if (!axil_resp.rvalid) begin
            $display("Bus hang: no read data for address 0x%02h", addr);
            error_count++;
        end else begin
            data = axil_resp.rdata;
            ok = 1'b1;
        end
    end
endtask

/* enable_generator_tb.sv */
// Testbench for the enable generator with a cycle model of counter and comparators
// Reference function, checking process, five tests and a closing summary
`timescale 1ns/1ps
`include "enable_gen_settings.svh"

module enable_generator_tb;

    localparam int COUNTER_WIDTH = `ENABLE_GEN_COUNTER_WIDTH;
    localparam int N_CHANNELS    = `ENABLE_GEN_N_CHANNELS;
    localparam int N_REGISTERS   = `ENABLE_GEN_N_REGISTERS;
    localparam int ADDR_WIDTH    = `ENABLE_GEN_AXIL_ADDR_WIDTH;
    localparam int DATA_WIDTH    = `ENABLE_GEN_AXIL_DATA_WIDTH;
    localparam logic [DATA_WIDTH-1:0] COUNT_MASK = DATA_WIDTH'((64'd1 << COUNTER_WIDTH) - 1);
    localparam logic [ADDR_WIDTH-1:0] UNMAPPED_ADDR = ADDR_WIDTH'(16 * 4);
    // Twice the summed cycle budgets of the five tests
    localparam int CYCLE_LIMIT = 2 * (150 + 500 + 1100 + 650 + 400);

    typedef struct packed {
        logic [COUNTER_WIDTH-1:0] count;
        logic [N_CHANNELS-1:0]    pulses;
    } prediction_t;

    logic                  clock;
    logic                  reset;
    axil_pkg::axil_req_t   axil_req;
    axil_pkg::axil_resp_t  axil_resp;
    logic                  ext_timebase;
    logic                  gen_enable_in;
    logic [N_CHANNELS-1:0] enable_out;

    enable_gen_pkg::gen_config_t model_cfg;
    enable_gen_pkg::gen_config_t next_cfg;
    logic [COUNTER_WIDTH-1:0]    model_count;
    logic                        model_tick;
    logic                        timebase_prev;
    logic [N_CHANNELS-1:0]       pending_pulses;
    logic [N_CHANNELS-1:0]       expected_out;
    prediction_t                 prediction;

    integer seed;
    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     cycle_count;

    enable_generator dut (
        .clock         (clock),
        .reset         (reset),
        .axil_req      (axil_req),
        .axil_resp     (axil_resp),
        .ext_timebase  (ext_timebase),
        .gen_enable_in (gen_enable_in),
        .enable_out    (enable_out)
    );

    `include "enable_generator_tb_bus.svh"

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Next count and the pulses that the new count fires one clock later
    function automatic prediction_t predict_next(
        input logic [COUNTER_WIDTH-1:0] count,
        input logic [COUNTER_WIDTH-1:0] period,
        input logic [N_CHANNELS-1:0][COUNTER_WIDTH-1:0] thresholds,
        input logic active,
        input logic tick
    );
        prediction_t result;
        int n;
        result.pulses = '0;
        result.count = count;
        if (!active) begin
            result.count = '0;
        end else if (tick) begin
            result.count = (count == period) ? '0 : count + COUNTER_WIDTH'(1);
            for (n = 0; n < N_CHANNELS; n++) begin
                result.pulses[n] = (result.count == thresholds[n]);
            end
        end
        return result;
    endfunction

    // Configuration as it stands after a bus write to one of the mapped words 0 to 4
    function automatic enable_gen_pkg::gen_config_t after_write(
        input enable_gen_pkg::gen_config_t cfg,
        input logic [ADDR_WIDTH-1:0] addr,
        input logic [DATA_WIDTH-1:0] data
    );
        enable_gen_pkg::gen_config_t updated;
        updated = cfg;
        case (int'(addr[ADDR_WIDTH-1:2]))
            0: begin
                updated.run = data[0];
                updated.use_ext_timebase = data[1];
            end
            1: updated.period = data[COUNTER_WIDTH-1:0];
            2: updated.thresholds[0] = data[COUNTER_WIDTH-1:0];
            3: updated.thresholds[1] = data[COUNTER_WIDTH-1:0];
            4: updated.thresholds[2] = data[COUNTER_WIDTH-1:0];
            default: begin
            end
        endcase
        return updated;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] reg_addr(input enable_gen_pkg::reg_index_e index);
        return ADDR_WIDTH'(int'(index) * 4);
    endfunction

    function automatic logic [DATA_WIDTH-1:0] random_below(input int limit);
        return DATA_WIDTH'({$random(seed)} % limit);
    endfunction

    // Model steps on the same edges as the DUT and takes a write in the awready cycle
    always @(posedge clock) begin
        if (reset) begin
            model_cfg = '0;
            model_count = '0;
            timebase_prev = 1'b0;
            pending_pulses = '0;
            expected_out = '0;
        end else begin
            expected_out = pending_pulses;
            next_cfg = model_cfg;
            if (axil_resp.awready && axil_resp.wready) begin
                next_cfg = after_write(model_cfg, axil_req.awaddr, axil_req.wdata);
            end
            model_tick = model_cfg.use_ext_timebase ? (ext_timebase && !timebase_prev) : 1'b1;
            // The comparators see the thresholds that hold after this edge
            prediction = predict_next(model_count, model_cfg.period, next_cfg.thresholds,
                                      model_cfg.run || gen_enable_in, model_tick);
            model_count = prediction.count;
            pending_pulses = prediction.pulses;
            timebase_prev = ext_timebase;
            model_cfg = next_cfg;
        end
    end

    always @(negedge clock) begin
        if (!reset) begin
            if (enable_out !== expected_out) begin
                $display("[ERROR] %0t: enable_out expected %b, got %b",
                         $time, expected_out, enable_out);
                error_count++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     error_count - errors_before);
        end
    endtask

    task automatic check_register_access;
        logic [DATA_WIDTH-1:0] values [N_REGISTERS];
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] expected;
        logic                  ok;
        int                    errors_before;
        int                    i;
        errors_before = error_count;
        for (i = 0; i < N_REGISTERS; i++) begin
            values[i] = $random(seed);
            write_register(ADDR_WIDTH'(i * 4), values[i]);
        end
        write_register(UNMAPPED_ADDR, $random(seed));
        for (i = 0; i < N_REGISTERS; i++) begin
            read_register(ADDR_WIDTH'(i * 4), data, ok);
            expected = (i == 0) ? (values[i] & 32'h3) : (values[i] & COUNT_MASK);
            if (ok && data !== expected) begin
                $display("[ERROR] %0t: register %0d read 0x%08h, expected 0x%08h",
                         $time, i, data, expected);
                error_count++;
            end
        end
        read_register(UNMAPPED_ADDR, data, ok);
        if (ok && data !== '0) begin
            $display("[ERROR] %0t: unmapped address read 0x%08h, expected 0", $time, data);
            error_count++;
        end
        report_test("register access", errors_before);
    endtask

    task automatic run_internal_timebase;
        int errors_before;
        int period;
        int silent_pulses;
        int pulses_seen;
        errors_before = error_count;
        silent_pulses = 0;
        pulses_seen = 0;
        // Stop first so the count restarts from zero below the new period
        write_register(reg_addr(enable_gen_pkg::CONTROL), 32'd0);
        period = 20 + random_below(41);
        write_register(reg_addr(enable_gen_pkg::PERIOD), period);
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_1), random_below(period + 1));
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_2), random_below(period + 1));
        // Channel 3 waits above the period and is never reached
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_3), period + 1 + random_below(20));
        write_register(reg_addr(enable_gen_pkg::CONTROL), 32'd1);
        repeat (400) begin
            @(posedge clock);
            if (enable_out[2]) silent_pulses++;
            if (enable_out[0]) pulses_seen++;
        end
        if (silent_pulses != 0) begin
            $display("[ERROR] %0t: channel 3 pulsed %0d times above the period",
                     $time, silent_pulses);
            error_count++;
        end
        if (pulses_seen == 0) begin
            $display("Channel 1 never pulsed with the internal timebase");
            error_count++;
        end
        report_test("internal timebase", errors_before);
    endtask

    task automatic run_external_timebase;
        int errors_before;
        int period;
        int run_left;
        int pulses_seen;
        errors_before = error_count;
        pulses_seen = 0;
        run_left = 0;
        // Stop first so the count restarts from zero below the new period
        write_register(reg_addr(enable_gen_pkg::CONTROL), 32'd0);
        period = 7 + random_below(9);
        write_register(reg_addr(enable_gen_pkg::PERIOD), period);
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_1), random_below(period + 1));
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_2), random_below(period + 1));
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_3), random_below(period + 1));
        write_register(reg_addr(enable_gen_pkg::CONTROL), 32'd3);
        repeat (1000) begin
            @(posedge clock);
            if (run_left == 0) begin
                ext_timebase <= !ext_timebase;
                run_left = 1 + random_below(6);
            end
            run_left--;
            if (enable_out != '0) pulses_seen++;
        end
        ext_timebase <= 1'b0;
        write_register(reg_addr(enable_gen_pkg::CONTROL), 32'd0);
        if (pulses_seen == 0) begin
            $display("No pulse was seen with the external timebase");
            error_count++;
        end
        report_test("external timebase", errors_before);
    endtask

    task automatic run_external_enable;
        int errors_before;
        int period;
        int stretch;
        int c;
        errors_before = error_count;
        period = 8 + random_below(8);
        write_register(reg_addr(enable_gen_pkg::PERIOD), period);
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_1), random_below(period + 1));
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_2), random_below(period + 1));
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_3), random_below(period + 1));
        write_register(reg_addr(enable_gen_pkg::CONTROL), 32'd0);
        repeat (6) begin
            stretch = 20 + random_below(40);
            @(posedge clock);
            gen_enable_in <= 1'b1;
            repeat (stretch) @(posedge clock);
            gen_enable_in <= 1'b0;
            stretch = 10 + random_below(20);
            for (c = 0; c < stretch; c++) begin
                @(posedge clock);
                // The last step of a high stretch can still show for two cycles
                if (c >= 2 && enable_out != '0) begin
                    $display("[ERROR] %0t: enable_out %b while gen_enable_in is low",
                             $time, enable_out);
                    error_count++;
                end
            end
        end
        report_test("external enable", errors_before);
    endtask

    task automatic run_stop_and_reprogram;
        int errors_before;
        int period;
        int gap;
        int c;
        errors_before = error_count;
        write_register(reg_addr(enable_gen_pkg::PERIOD), 32'd30);
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_1), 32'd5);
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_2), 32'd10);
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_3), 32'd15);
        write_register(reg_addr(enable_gen_pkg::CONTROL), 32'd1);
        repeat (45) @(posedge clock);
        write_register(reg_addr(enable_gen_pkg::CONTROL), 32'd0);
        @(posedge clock);
        for (c = 0; c < 20; c++) begin
            @(posedge clock);
            if (enable_out != '0) begin
                $display("[ERROR] %0t: enable_out %b after stop", $time, enable_out);
                error_count++;
            end
        end
        period = 10 + random_below(20);
        write_register(reg_addr(enable_gen_pkg::PERIOD), period);
        write_register(reg_addr(enable_gen_pkg::THRESHOLD_1), random_below(period + 1));
        write_register(reg_addr(enable_gen_pkg::CONTROL), 32'd1);
        c = 0;
        @(posedge clock);
        while (!enable_out[0] && c < 100) begin
            @(posedge clock);
            c++;
        end
        if (!enable_out[0]) begin
            $display("Channel 1 did not pulse after the restart");
            error_count++;
        end else begin
            repeat (3) begin
                gap = 0;
                do begin
                    @(posedge clock);
                    gap++;
                end while (!enable_out[0] && gap < 100);
                if (gap != period + 1) begin
                    $display("[ERROR] %0t: pulse spacing expected %0d cycles, got %0d",
                             $time, period + 1, gap);
                    error_count++;
                end
            end
        end
        write_register(reg_addr(enable_gen_pkg::CONTROL), 32'd0);
        report_test("stop and reprogram", errors_before);
    endtask

    initial begin
        seed = 32'heacb_b1ce;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle_count = 0;
        reset <= 1'b1;
        axil_req <= '0;
        ext_timebase <= 1'b0;
        gen_enable_in <= 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        check_register_access();
        run_internal_timebase();
        run_external_timebase();
        run_external_enable();
        run_stop_and_reprogram();
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+.
axil_pkg.sv
enable_gen_pkg.sv
axil_register_cu.sv
enable_counter.sv
enable_comparator_bank.sv
enable_generator.sv
enable_generator_tb.sv

/* Makefile */
# Verilator build and run of the enable generator testbench
VERILATOR ?= verilator
TOP       ?= enable_generator_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
